// File: compile.f
+incdir+.
cu_pkg.sv
instr_decoder.sv
cycle_sequencer.sv
control_word_gen.sv
multicycle_control.sv
tb_multicycle_control.sv

// File: control_word_gen.sv
`timescale 1ns/100ps

module control_word_gen (
    input  cu_pkg::cu_state_t  state,
    input  logic               ov,
    output cu_pkg::ctrl_word_t ctrl
);
    import cu_pkg::*;

    always_comb begin
        ctrl = CTRL_IDLE;
        case (state)
            // Stack pointer load after reset
            ST_INIT: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = RD_SP;
                ctrl.mem_to_reg = WB_SP_INIT;
            end
            // PC + 4 runs through the whole header
            ST_FETCH_WAIT: begin
                ctrl.iord      = ADR_PC;
                ctrl.alu_src_a = A_PC;
                ctrl.alu_src_b = B_FOUR;
                ctrl.alu_op    = ALU_ADD;
            end
            ST_FETCH_LATCH: begin
                ctrl.pc_write  = 1'b1;
                ctrl.ir_write  = 1'b1;
                ctrl.pc_src    = PC_ALU;
                ctrl.alu_src_a = A_PC;
                ctrl.alu_src_b = B_FOUR;
                ctrl.alu_op    = ALU_ADD;
            end
            ST_DECODE: begin
                ctrl.a_write   = 1'b1;
                ctrl.b_write   = 1'b1;
                ctrl.alu_src_a = A_PC;
                ctrl.alu_src_b = B_FOUR;
                ctrl.alu_op    = ALU_ADD;
            end
            ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND: begin
                ctrl.alu_reg_write = 1'b1;
                ctrl.alu_src_a     = A_REG;
                ctrl.alu_src_b     = B_REG;
                case (state)
                    ST_ALU_SUB: ctrl.alu_op = ALU_SUB;
                    ST_ALU_AND: ctrl.alu_op = ALU_AND;
                    default:    ctrl.alu_op = ALU_ADD;
                endcase
            end
            // Base plus offset shares the immediate adds
            ST_ALU_IMM_TRAP, ST_ALU_IMM, ST_LS_ADDR: begin
                ctrl.alu_reg_write = 1'b1;
                ctrl.alu_src_a     = A_REG;
                ctrl.alu_src_b     = B_SIGN_IMM;
                ctrl.alu_op        = ALU_ADD;
            end
            // Overflow cancels the trapping write-backs
            ST_WB_RD: begin
                ctrl.reg_write  = ~ov;
                ctrl.reg_dst    = RD_RD;
                ctrl.mem_to_reg = WB_ALU_OUT;
            end
            ST_WB_RT_TRAP: begin
                ctrl.reg_write  = ~ov;
                ctrl.reg_dst    = RD_RT;
                ctrl.mem_to_reg = WB_ALU_OUT;
            end
            ST_WB_RT: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = RD_RT;
                ctrl.mem_to_reg = WB_ALU_OUT;
            end
            ST_MEM_READ: begin
                ctrl.iord = ADR_ALU_OUT;
            end
            ST_MDR_WORD, ST_MDR_HALF, ST_MDR_BYTE: begin
                ctrl.mdr_write = 1'b1;
                case (state)
                    ST_MDR_HALF: ctrl.mem_to_mdr = SZ_HALF;
                    ST_MDR_BYTE: ctrl.mem_to_mdr = SZ_BYTE;
                    default:     ctrl.mem_to_mdr = SZ_WORD;
                endcase
            end
            ST_LOAD_WB: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = RD_RT;
                ctrl.mem_to_reg = WB_MDR;
            end
            ST_STORE_WORD, ST_STORE_HALF, ST_STORE_BYTE: begin
                ctrl.mem_wr = 1'b1;
                ctrl.iord   = ADR_ALU_OUT;
                case (state)
                    ST_STORE_HALF: ctrl.b_to_mem = SZ_HALF;
                    ST_STORE_BYTE: ctrl.b_to_mem = SZ_BYTE;
                    default:       ctrl.b_to_mem = SZ_WORD;
                endcase
            end
            // Vector read while the ALU backs PC up to the faulting instruction
            ST_EXC_NOOP, ST_EXC_OVF: begin
                ctrl.iord        = ADR_VECTOR;
                ctrl.except_code = (state == ST_EXC_OVF) ? EXC_OVF : EXC_NOOP;
                ctrl.alu_src_a   = A_PC;
                ctrl.alu_src_b   = B_FOUR;
                ctrl.alu_op      = ALU_SUB;
            end
            ST_EXC_COMMIT: begin
                ctrl.epc_write = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_src    = PC_VECTOR;
            end
            default: begin
                ctrl = CTRL_IDLE;
            end
        endcase
    end

endmodule

// File: cu_pkg.sv
package cu_pkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LB    = 6'h20;
    localparam opcode_t OP_LH    = 6'h21;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SB    = 6'h28;
    localparam opcode_t OP_SH    = 6'h29;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;

    // Memory read wait, in cycles
    localparam int unsigned MEM_LATENCY = 3;
    localparam int unsigned WAIT_W      = 2;

    typedef logic [WAIT_W-1:0] wait_cnt_t;

    typedef enum logic [3:0] {
        CLS_ADD, CLS_SUB, CLS_AND,
        CLS_ADDI, CLS_ADDIU,
        CLS_LW, CLS_LH, CLS_LB,
        CLS_SW, CLS_SH, CLS_SB,
        CLS_UNKNOWN
    } instr_class_t;

    typedef enum logic [4:0] {
        ST_INIT,
        ST_FETCH_WAIT, ST_FETCH_LATCH, ST_DECODE, ST_DISPATCH,
        ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND, ST_ALU_IMM_TRAP, ST_ALU_IMM,
        ST_WB_RD, ST_WB_RT_TRAP, ST_WB_RT,
        ST_LS_ADDR, ST_MEM_READ,
        ST_MDR_WORD, ST_MDR_HALF, ST_MDR_BYTE, ST_LOAD_WB,
        ST_STORE_WORD, ST_STORE_HALF, ST_STORE_BYTE,
        ST_EXC_NOOP, ST_EXC_OVF, ST_EXC_COMMIT
    } cu_state_t;

    // Datapath selects, first member is zero
    typedef enum logic [1:0] {RD_RT, RD_RD, RD_SP} reg_dst_t;
    typedef enum logic [1:0] {EXC_NOOP, EXC_OVF} exc_code_t;
    typedef enum logic [1:0] {SZ_WORD, SZ_HALF, SZ_BYTE} size_sel_t;
    typedef enum logic [1:0] {A_PC, A_REG} alu_a_sel_t;
    typedef enum logic [2:0] {B_REG, B_FOUR, B_SIGN_IMM} alu_b_sel_t;
    typedef enum logic [2:0] {ALU_NONE, ALU_ADD, ALU_AND, ALU_SUB} alu_op_t;
    typedef enum logic [1:0] {ADR_PC, ADR_ALU_OUT, ADR_VECTOR} addr_sel_t;
    typedef enum logic [1:0] {PC_ALU, PC_VECTOR} pc_src_t;
    typedef enum logic [2:0] {WB_ALU_OUT, WB_MDR, WB_SP_INIT} wb_sel_t;

    typedef struct packed {
        logic       pc_write;
        logic       mem_wr;
        logic       ir_write;
        logic       a_write;
        logic       b_write;
        logic       mdr_write;
        logic       alu_reg_write;
        logic       epc_write;
        logic       reg_write;
        reg_dst_t   reg_dst;
        exc_code_t  except_code;
        // Memory to MDR and B to memory
        size_sel_t  mem_to_mdr;
        size_sel_t  b_to_mem;
        alu_a_sel_t alu_src_a;
        alu_b_sel_t alu_src_b;
        alu_op_t    alu_op;
        addr_sel_t  iord;
        pc_src_t    pc_src;
        wb_sel_t    mem_to_reg;
    } ctrl_word_t;

    // Nothing written, every select at its zero member
    localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

// File: cycle_sequencer.sv
`timescale 1ns/100ps

module cycle_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  cu_pkg::instr_class_t instr_class,
    input  logic                 ov,
    output cu_pkg::cu_state_t    state
);
    import cu_pkg::*;

    cu_state_t state_next;
    wait_cnt_t wait_cnt;
    logic      wait_done;
    logic      init_pend;

    assign wait_done = (wait_cnt == wait_cnt_t'(MEM_LATENCY - 1));

    // Dispatch is held during reset so the control word stays idle
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_DISPATCH;
            init_pend <= 1'b1;
            wait_cnt  <= '0;
        end else begin
            state     <= state_next;
            init_pend <= 1'b0;
            // Only the wait states repeat, any entry starts a new count
            if (state_next != state) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_INIT: begin
                state_next = ST_FETCH_WAIT;
            end
            ST_FETCH_WAIT: begin
                if (wait_done) begin
                    state_next = ST_FETCH_LATCH;
                end
            end
            ST_FETCH_LATCH: begin
                state_next = ST_DECODE;
            end
            ST_DECODE: begin
                state_next = ST_DISPATCH;
            end
            ST_DISPATCH: begin
                if (init_pend) begin
                    state_next = ST_INIT;
                end else begin
                    case (instr_class)
                        CLS_ADD:   state_next = ST_ALU_ADD;
                        CLS_SUB:   state_next = ST_ALU_SUB;
                        CLS_AND:   state_next = ST_ALU_AND;
                        CLS_ADDI:  state_next = ST_ALU_IMM_TRAP;
                        CLS_ADDIU: state_next = ST_ALU_IMM;
                        CLS_LW, CLS_LH, CLS_LB,
                        CLS_SW, CLS_SH, CLS_SB: begin
                            state_next = ST_LS_ADDR;
                        end
                        default:   state_next = ST_EXC_NOOP;
                    endcase
                end
            end
            ST_ALU_ADD, ST_ALU_SUB, ST_ALU_AND: begin
                state_next = ST_WB_RD;
            end
            ST_ALU_IMM_TRAP: begin
                state_next = ST_WB_RT_TRAP;
            end
            ST_ALU_IMM: begin
                state_next = ST_WB_RT;
            end
            // ov is valid once the ALU result is registered
            ST_WB_RD, ST_WB_RT_TRAP: begin
                state_next = ov ? ST_EXC_OVF : ST_FETCH_WAIT;
            end
            ST_LS_ADDR: begin
                state_next = ST_MEM_READ;
            end
            ST_MEM_READ: begin
                if (wait_done) begin
                    case (instr_class)
                        CLS_LW:  state_next = ST_MDR_WORD;
                        CLS_LH:  state_next = ST_MDR_HALF;
                        CLS_LB:  state_next = ST_MDR_BYTE;
                        CLS_SW:  state_next = ST_STORE_WORD;
                        CLS_SH:  state_next = ST_STORE_HALF;
                        CLS_SB:  state_next = ST_STORE_BYTE;
                        default: state_next = ST_FETCH_WAIT;
                    endcase
                end
            end
            ST_MDR_WORD, ST_MDR_HALF, ST_MDR_BYTE: begin
                state_next = ST_LOAD_WB;
            end
            ST_EXC_NOOP, ST_EXC_OVF: begin
                if (wait_done) begin
                    state_next = ST_EXC_COMMIT;
                end
            end
            ST_WB_RT, ST_LOAD_WB, ST_STORE_WORD, ST_STORE_HALF, ST_STORE_BYTE,
            ST_EXC_COMMIT: begin
                state_next = ST_FETCH_WAIT;
            end
            default: begin
                state_next = ST_FETCH_WAIT;
            end
        endcase
    end

endmodule

// File: instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  cu_pkg::opcode_t      opcode,
    input  cu_pkg::funct_t       funct,
    output cu_pkg::instr_class_t instr_class
);
    import cu_pkg::*;

    always_comb begin
        instr_class = CLS_UNKNOWN;
        case (opcode)
            OP_RTYPE: begin
                // Only add, sub and and remain among the R-type functions
                case (funct)
                    FN_ADD: begin
                        instr_class = CLS_ADD;
                    end
                    FN_SUB: begin
                        instr_class = CLS_SUB;
                    end
                    FN_AND: begin
                        instr_class = CLS_AND;
                    end
                    default: begin
                        instr_class = CLS_UNKNOWN;
                    end
                endcase
            end
            OP_ADDI: begin
                instr_class = CLS_ADDI;
            end
            OP_ADDIU: begin
                instr_class = CLS_ADDIU;
            end
            OP_LW: begin
                instr_class = CLS_LW;
            end
            OP_LH: begin
                instr_class = CLS_LH;
            end
            OP_LB: begin
                instr_class = CLS_LB;
            end
            OP_SW: begin
                instr_class = CLS_SW;
            end
            OP_SH: begin
                instr_class = CLS_SH;
            end
            OP_SB: begin
                instr_class = CLS_SB;
            end
            default: begin
                instr_class = CLS_UNKNOWN;
            end
        endcase
    end

endmodule

// File: multicycle_control.sv
`timescale 1ns/100ps

module multicycle_control (
    input  logic               clk,
    input  logic               reset,
    input  cu_pkg::opcode_t    opcode,
    input  cu_pkg::funct_t     funct,
    input  logic               ov,
    output cu_pkg::ctrl_word_t ctrl
);
    import cu_pkg::*;

    instr_class_t instr_class;
    cu_state_t    state;

    instr_decoder u_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    cycle_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .ov          (ov),
        .state       (state)
    );

    control_word_gen u_ctrl_gen (
        .state (state),
        .ov    (ov),
        .ctrl  (ctrl)
    );

endmodule

// File: tb_control_model.svh
// Expected control words, oldest first
ctrl_word_t exp_q[$];

// PC + 4 selects shared by the fetch header
function automatic ctrl_word_t pc_plus_four();
    ctrl_word_t w;
    w = '0;
    w.iord      = ADR_PC;
    w.alu_src_a = A_PC;
    w.alu_src_b = B_FOUR;
    w.alu_op    = ALU_ADD;
    return w;
endfunction

function automatic ctrl_word_t imm_add_word();
    ctrl_word_t w;
    w = '0;
    w.alu_reg_write = 1'b1;
    w.alu_src_a     = A_REG;
    w.alu_src_b     = B_SIGN_IMM;
    w.alu_op        = ALU_ADD;
    return w;
endfunction

task automatic push_sp_init();
    ctrl_word_t w;
    w = '0;
    w.reg_write  = 1'b1;
    w.reg_dst    = RD_SP;
    w.mem_to_reg = WB_SP_INIT;
    exp_q.push_back(w);
endtask

task automatic push_header();
    ctrl_word_t w;
    for (int i = 0; i < MEM_LATENCY; i++) begin
        exp_q.push_back(pc_plus_four());
    end
    w = pc_plus_four();
    w.pc_write = 1'b1;
    w.ir_write = 1'b1;
    exp_q.push_back(w);
    w = pc_plus_four();
    w.a_write = 1'b1;
    w.b_write = 1'b1;
    exp_q.push_back(w);
    // Dispatch cycle drives nothing
    exp_q.push_back(ctrl_word_t'('0));
endtask

task automatic push_exception(input exc_code_t code);
    ctrl_word_t w;
    w = '0;
    w.iord        = ADR_VECTOR;
    w.except_code = code;
    w.alu_src_a   = A_PC;
    w.alu_src_b   = B_FOUR;
    w.alu_op      = ALU_SUB;
    for (int i = 0; i < MEM_LATENCY; i++) begin
        exp_q.push_back(w);
    end
    w = '0;
    w.epc_write = 1'b1;
    w.pc_write  = 1'b1;
    w.pc_src    = PC_VECTOR;
    exp_q.push_back(w);
endtask

// Overflow keeps the selects but drops the register write
task automatic push_writeback(input reg_dst_t dst, input logic cancel);
    ctrl_word_t w;
    w = '0;
    w.reg_write  = ~cancel;
    w.reg_dst    = dst;
    w.mem_to_reg = WB_ALU_OUT;
    exp_q.push_back(w);
    if (cancel) begin
        push_exception(EXC_OVF);
    end
endtask

task automatic push_rtype(input alu_op_t op, input logic ovf);
    ctrl_word_t w;
    w = '0;
    w.alu_reg_write = 1'b1;
    w.alu_src_a     = A_REG;
    w.alu_src_b     = B_REG;
    w.alu_op        = op;
    exp_q.push_back(w);
    push_writeback(RD_RD, ovf);
endtask

task automatic push_address();
    ctrl_word_t w;
    exp_q.push_back(imm_add_word());
    w = '0;
    w.iord = ADR_ALU_OUT;
    for (int i = 0; i < MEM_LATENCY; i++) begin
        exp_q.push_back(w);
    end
endtask

task automatic push_load(input size_sel_t size);
    ctrl_word_t w;
    push_address();
    w = '0;
    w.mdr_write  = 1'b1;
    w.mem_to_mdr = size;
    exp_q.push_back(w);
    w = '0;
    w.reg_write  = 1'b1;
    w.reg_dst    = RD_RT;
    w.mem_to_reg = WB_MDR;
    exp_q.push_back(w);
endtask

task automatic push_store(input size_sel_t size);
    ctrl_word_t w;
    push_address();
    w = '0;
    w.mem_wr   = 1'b1;
    w.iord     = ADR_ALU_OUT;
    w.b_to_mem = size;
    exp_q.push_back(w);
endtask

task automatic push_instruction(input instr_class_t cls, input logic ovf);
    push_header();
    case (cls)
        CLS_ADD:   push_rtype(ALU_ADD, ovf);
        CLS_SUB:   push_rtype(ALU_SUB, ovf);
        CLS_AND:   push_rtype(ALU_AND, ovf);
        CLS_ADDI: begin
            exp_q.push_back(imm_add_word());
            push_writeback(RD_RT, ovf);
        end
        CLS_ADDIU: begin
            exp_q.push_back(imm_add_word());
            push_writeback(RD_RT, 1'b0);
        end
        CLS_LW:    push_load(SZ_WORD);
        CLS_LH:    push_load(SZ_HALF);
        CLS_LB:    push_load(SZ_BYTE);
        CLS_SW:    push_store(SZ_WORD);
        CLS_SH:    push_store(SZ_HALF);
        CLS_SB:    push_store(SZ_BYTE);
        default:   push_exception(EXC_NOOP);
    endcase
endtask

// File: tb_multicycle_control.sv
`timescale 1ns/100ps

module tb_multicycle_control;
    import cu_pkg::*;

    localparam int unsigned NUM_INSTR  = 400;
    // Longest instruction is 12 cycles, plus reset and margin
    localparam int unsigned MAX_CYCLES = 6000;

    logic        clk;
    logic        reset;
    opcode_t     opcode;
    funct_t      funct;
    logic        ov;
    ctrl_word_t  ctrl;
    integer      seed;
    int unsigned cycle_cnt;

    `include "tb_control_model.svh"

    multicycle_control UUT (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ov     (ov),
        .ctrl   (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout: test still running after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic compare_ctrl(input ctrl_word_t expected, input ctrl_word_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: ctrl expected %h, got %h", $time, expected, actual);
            $display("Simulation failed");
            $fatal(1, "control word mismatch");
        end
    endtask

    function automatic logic is_kept_opcode(input opcode_t op);
        case (op)
            OP_RTYPE, OP_ADDI, OP_ADDIU, OP_LW, OP_LH, OP_LB,
            OP_SW, OP_SH, OP_SB: begin
                return 1'b1;
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    task automatic pick_instruction(output instr_class_t cls, output opcode_t op,
                                    output funct_t fn, output logic ovf);
        int unsigned r;
        logic [31:0] bits;
        r    = $unsigned($random(seed)) % 100;
        bits = $random(seed);
        // Non R-type opcodes get a random funct field
        fn   = bits[5:0];
        ovf  = bits[8];
        if (r < 10) begin
            cls = CLS_UNKNOWN;
            if (bits[24]) begin
                op = OP_RTYPE;
                while (fn == FN_ADD || fn == FN_SUB || fn == FN_AND) begin
                    fn = fn + 1'b1;
                end
            end else begin
                op = bits[21:16];
                while (is_kept_opcode(op)) begin
                    op = op + 1'b1;
                end
            end
        end else begin
            cls = instr_class_t'($unsigned($random(seed)) % 11);
            case (cls)
                CLS_ADD: begin
                    op = OP_RTYPE;
                    fn = FN_ADD;
                end
                CLS_SUB: begin
                    op = OP_RTYPE;
                    fn = FN_SUB;
                end
                CLS_AND: begin
                    op = OP_RTYPE;
                    fn = FN_AND;
                end
                CLS_ADDI:  op = OP_ADDI;
                CLS_ADDIU: op = OP_ADDIU;
                CLS_LW:    op = OP_LW;
                CLS_LH:    op = OP_LH;
                CLS_LB:    op = OP_LB;
                CLS_SW:    op = OP_SW;
                CLS_SH:    op = OP_SH;
                default:   op = OP_SB;
            endcase
        end
    endtask

    initial begin
        instr_class_t cls;
        opcode_t      next_op;
        funct_t       next_fn;
        logic         next_ov;
        int           idx;
        seed      = 32'hb8bc7e4a;
        cycle_cnt = 0;
        reset     = 1'b1;
        opcode    = OP_RTYPE;
        funct     = '0;
        ov        = 1'b0;

        // Idle through reset and the cycle after it falls
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            if (i == 15) begin
                reset = 1'b0;
            end
            @(negedge clk);
            compare_ctrl(ctrl_word_t'('0), ctrl);
        end

        push_sp_init();
        for (int n = 0; n <= NUM_INSTR; n++) begin
            if (n > 0) begin
                pick_instruction(cls, next_op, next_fn, next_ov);
                push_instruction(cls, next_ov);
            end
            idx = 0;
            while (exp_q.size() > 0) begin
                @(posedge clk);
                #1;
                // New instruction once the IR has been loaded
                if (n > 0 && idx == MEM_LATENCY + 1) begin
                    opcode = next_op;
                    funct  = next_fn;
                    ov     = next_ov;
                end
                @(negedge clk);
                compare_ctrl(exp_q.pop_front(), ctrl);
                idx++;
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
